/* vlog.f */
+incdir+include
logic/frontend_pkg.sv
logic/fetch_pc_gen.sv
logic/inst_fetch.sv
logic/multi_port_fifo.sv
logic/inst_decoder.sv
logic/issue_buffer.sv
logic/core_frontend.sv
testbench/frontend_checker.sv
testbench/tb_frontend.sv

/* Bender.yml */
package:
  name: core_frontend

sources:
  - include_dirs:
      - include
    files:
      - logic/frontend_pkg.sv
      - logic/fetch_pc_gen.sv
      - logic/inst_fetch.sv
      - logic/multi_port_fifo.sv
      - logic/inst_decoder.sv
      - logic/issue_buffer.sv
      - logic/core_frontend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/frontend_checker.sv
      - testbench/tb_frontend.sv

/* testbench/tb_frontend.sv */
module tb_frontend import frontend_pkg::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_PC  = 32'h1c00_0000;
  localparam int          NUM_TESTS = 5;

  logic             clk;
  logic             rst_n;
  backend_ctrl_t    ctrl;
  bus_req_t         bus_req;
  bus_resp_t        bus_resp;
  issue_pkt_t [1:0] inst;
  logic [1:0]       inst_valid;
  int               test_id;
  int               issued;
  int               chk_errors;
  logic [31:0]      mask_rng;
  logic [31:0]      bus_rng;

  core_frontend #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (8)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .bus_req_o    (bus_req),
    .bus_resp_i   (bus_resp),
    .inst_o       (inst),
    .inst_valid_o (inst_valid)
  );

  frontend_checker #(.RESET_PC(RESET_PC)) u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl),
    .bus_req_i    (bus_req),
    .bus_resp_i   (bus_resp),
    .inst_i       (inst),
    .inst_valid_i (inst_valid),
    .test_id_i    (test_id),
    .issued_o     (issued),
    .errors_o     (chk_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // drive next cycle's inputs with strobes lasting one cycle
  task automatic step();
    @(posedge clk);
    #2;
    mask_rng = xorshift(mask_rng);
    case (mask_rng % 3)
      0:       ctrl.issue = 2'b00;
      1:       ctrl.issue = 2'b01;
      default: ctrl.issue = 2'b11;
    endcase
    ctrl.redirect = 1'b0;
    ctrl.wait_req = 1'b0;
  endtask

  task automatic run_until(input int n);
    int target;
    target = issued + n;
    while (issued < target) step();
  endtask

  task automatic redirect_to(input logic [31:0] target);
    step();
    ctrl.redirect = 1'b1;
    ctrl.target = target;
  endtask

  // memory answers each request after 1 to 4 cycles
  initial begin : memory_model
    int          lat;
    logic        busy;
    logic [31:0] addr;
    busy = 1'b0;
    lat = 0;
    addr = '0;
    bus_resp = '0;
    forever begin
      @(posedge clk);
      #2;
      bus_resp.valid = 1'b0;
      if (!rst_n) begin
        busy = 1'b0;
      end else if (busy) begin
        lat--;
        if (lat == 0) begin
          bus_resp.valid = 1'b1;
          bus_resp.data = {u_chk.mem_word(addr + 32'd4), u_chk.mem_word(addr)};
          busy = 1'b0;
        end
      end else if (bus_req.valid) begin
        busy = 1'b1;
        addr = bus_req.addr;
        bus_rng = xorshift(bus_rng);
        lat = int'(bus_rng[1:0]) + 1;
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * 100 + 2000) @(posedge clk);
    $display("watchdog expired, the instruction stream stopped making progress");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    ctrl = '0;
    test_id = 0;
    mask_rng = 32'hbe3a;
    bus_rng = xorshift(32'hbe3a ^ 32'h5555_0000);
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_id = 1;
    run_until(40);
    test_id = 2;
    run_until(40);

    test_id = 3;
    redirect_to(32'h1c00_1000);
    run_until(20);
    // bit 2 set so only the upper word is used
    redirect_to(32'h1c00_2004);
    run_until(20);

    test_id = 4;
    run_until(300);

    test_id = 5;
    step();
    ctrl.wait_req = 1'b1;
    repeat (30) step();
    ctrl.irq = 1'b1;
    repeat (3) step();
    ctrl.irq = 1'b0;
    run_until(30);

    test_id = 99;
    repeat (2) step();
    if (chk_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/frontend_checker.sv */
`include "frontend_defs.svh"

module frontend_checker import frontend_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
  input  logic             clk,
  input  logic             rst_n,
  input  backend_ctrl_t    ctrl_i,
  input  bus_req_t         bus_req_i,
  input  bus_resp_t        bus_resp_i,
  input  issue_pkt_t [1:0] inst_i,
  input  logic [1:0]       inst_valid_i,
  input  int               test_id_i,
  output int               issued_o,
  output int               errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] exp_pc;
  int          cur_test;
  int          test_checks;
  int          test_err;
  int          total_err;
  int          tests_done;
  int          rst_cycles;
  logic        redirect_q;
  logic        req_q;
  logic        resp_q;
  logic [31:0] addr_q;
  logic        idle_pending;
  logic        idle_armed;

  // memory word built from one of eight templates with register fields hashed from the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    h  = addr * 32'h9e37_79b1;
    h  = h ^ (h >> 15);
    rd = h[4:0];
    rj = h[9:5];
    rk = h[14:10];
    case (h[31:29])
      3'd0:    return {`OPC_ADD_W_31_15, rk, rj, rd};
      3'd1:    return {`OPC_ADDI_W_31_22, h[21:10], rj, rd};
      3'd2:    return {`OPC_LD_W_31_22, h[21:10], rj, rd};
      3'd3:    return {`OPC_ST_W_31_22, h[21:10], rj, rd};
      3'd4:    return {`OPC_BEQ_31_26, h[25:10], rj, rd};
      3'd5:    return {`OPC_BL_31_26, h[25:0]};
      3'd6:    return {`OPC_JIRL_31_26, h[25:10], rj, rd};
      default: return {`OPC_IDLE_31_15, h[14:0]};
    endcase
  endfunction

  // expected issue packet for the instruction at pc
  function automatic issue_pkt_t expect_pkt(input logic [31:0] pc);
    issue_pkt_t  p;
    logic [31:0] word;
    word = mem_word(pc);
    p = '0;
    p.pc = pc;
    p.inst = word;
    p.imm = word[25:0];
    p.info.cls = CLS_INVALID;
    if (word[31:15] == `OPC_ADD_W_31_15) begin
      p.info = '{CLS_ALU3R, `REG_R0_RK, `REG_R1_RJ, `REG_W_RD};
    end else if (word[31:15] == `OPC_IDLE_31_15) begin
      p.info.cls = CLS_IDLE;
    end else if (word[31:22] == `OPC_ADDI_W_31_22) begin
      p.info = '{CLS_ALUI, `REG_R0_NONE, `REG_R1_RJ, `REG_W_RD};
    end else if (word[31:22] == `OPC_LD_W_31_22) begin
      p.info = '{CLS_LOAD, `REG_R0_NONE, `REG_R1_RJ, `REG_W_RD};
    end else if (word[31:22] == `OPC_ST_W_31_22) begin
      p.info = '{CLS_STORE, `REG_R0_RD, `REG_R1_RJ, `REG_W_NONE};
    end else if (word[31:26] == `OPC_BEQ_31_26) begin
      p.info = '{CLS_BRANCH, `REG_R0_RD, `REG_R1_RJ, `REG_W_NONE};
    end else if (word[31:26] == `OPC_BL_31_26) begin
      p.info = '{CLS_BL, `REG_R0_NONE, `REG_R1_NONE, `REG_W_R1};
    end else if (word[31:26] == `OPC_JIRL_31_26) begin
      p.info = '{CLS_JIRL, `REG_R0_NONE, `REG_R1_RJ, `REG_W_RD};
    end
    if (p.info.r0_sel == `REG_R0_RK) p.regs.r_reg[0] = word[14:10];
    if (p.info.r0_sel == `REG_R0_RD) p.regs.r_reg[0] = word[4:0];
    if (p.info.r1_sel == `REG_R1_RJ) p.regs.r_reg[1] = word[9:5];
    if (p.info.w_sel == `REG_W_RD) p.regs.w_reg = word[4:0];
    if (p.info.w_sel == `REG_W_R1) p.regs.w_reg = 5'd1;
    return p;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_stream";
      2:       return "decode_fields";
      3:       return "redirect";
      4:       return "random_stream";
      5:       return "idle_wait";
      default: return "setup";
    endcase
  endfunction

  task automatic mismatch(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("error %s: %s expected %h actual %h", test_name(cur_test), what, exp_v, act_v);
    test_err++;
    total_err++;
  endtask

  task automatic fault(input string msg);
    $display("%s: %s", test_name(cur_test), msg);
    test_err++;
    total_err++;
  endtask

  task automatic check_slot(input issue_pkt_t act);
    issue_pkt_t exp;
    if (act.pc != exp_pc) begin
      mismatch("pc", exp_pc, act.pc);
      // resync so one gap is reported once
      exp_pc = act.pc;
    end
    exp = expect_pkt(exp_pc);
    if (act.inst != exp.inst) mismatch($sformatf("inst at %h", exp_pc), exp.inst, act.inst);
    if (act.info != exp.info) mismatch($sformatf("decode at %h", exp_pc), exp.info, act.info);
    if (act.regs != exp.regs) mismatch($sformatf("regs at %h", exp_pc), exp.regs, act.regs);
    if (act.imm != exp.imm) mismatch($sformatf("imm at %h", exp_pc), exp.imm, act.imm);
    exp_pc = exp_pc + 32'd4;
    test_checks++;
    issued_o++;
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      $display("test %s: %0d instructions checked, %0d errors",
               test_name(cur_test), test_checks, test_err);
      tests_done++;
    end
    test_checks = 0;
    test_err = 0;
  endtask

  initial begin
    exp_pc = RESET_PC;
    cur_test = 0;
    test_checks = 0;
    test_err = 0;
    total_err = 0;
    tests_done = 0;
    rst_cycles = 0;
    redirect_q = 1'b0;
    req_q = 1'b0;
    resp_q = 1'b0;
    addr_q = '0;
    idle_pending = 1'b0;
    idle_armed = 1'b0;
    issued_o = 0;
  end

  assign errors_o = total_err;

  always @(posedge clk) begin : monitor
    logic [1:0] take;
    if (!rst_n) begin
      exp_pc = RESET_PC;
      if (rst_cycles > 0 && (bus_req_i.valid || inst_valid_i != 2'b00)) begin
        fault("bus request or inst_valid high during reset");
      end
      rst_cycles++;
    end else begin
      if (test_id_i != cur_test) begin
        finish_test();
        cur_test = test_id_i;
        if (cur_test == 99) begin
          $display("totals: %0d tests, %0d instructions, %0d errors",
                   tests_done, issued_o, total_err);
        end
      end
      if (req_q && !resp_q && (!bus_req_i.valid || bus_req_i.addr != addr_q)) begin
        fault("bus request dropped or changed address before its response");
      end
      if (bus_req_i.valid && bus_req_i.addr[2:0] != 3'b000) begin
        fault($sformatf("bus request address %h is not 8-byte aligned", bus_req_i.addr));
      end
      if (redirect_q && inst_valid_i != 2'b00) begin
        fault("inst_valid still set in the cycle after a redirect");
      end
      if (idle_armed && bus_req_i.valid && !req_q) begin
        fault("new bus request raised during idle wait");
      end
      take[0] = inst_valid_i[0] && ctrl_i.issue[0];
      take[1] = take[0] && inst_valid_i[1] && ctrl_i.issue[1];
      for (int s = 0; s < 2; s++) begin
        if (take[s]) check_slot(inst_i[s]);
      end
      if (ctrl_i.redirect) exp_pc = ctrl_i.target;
      // interrupt wins over a wait in the same cycle
      idle_armed = idle_pending;
      if (ctrl_i.irq) begin
        idle_pending = 1'b0;
        idle_armed = 1'b0;
      end else if (ctrl_i.wait_req) begin
        idle_pending = 1'b1;
      end
      redirect_q = ctrl_i.redirect;
      req_q = bus_req_i.valid;
      resp_q = bus_resp_i.valid;
      addr_q = bus_req_i.addr;
    end
  end

endmodule

/* logic/core_frontend.sv */
module core_frontend import frontend_pkg::*; #(
  parameter logic [31:0] RESET_PC    = 32'h1c00_0000,
  parameter int          QUEUE_DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  backend_ctrl_t    ctrl_i,
  output bus_req_t         bus_req_o,
  input  bus_resp_t        bus_resp_i,
  output issue_pkt_t [1:0] inst_o,
  output logic [1:0]       inst_valid_o
);

  logic [31:0]        pc;
  logic [1:0]         slot_mask;
  logic               fetch_en;
  logic               accept;
  logic               pkt_valid;
  fetch_pkt_t         pkt;
  logic               q_ready;
  logic [1:0]         wr_num;
  queue_entry_t [1:0] wr_data;
  logic [1:0]         rd_valid;
  queue_entry_t [1:0] rd_data;
  logic [1:0]         pop_num;
  issue_pkt_t [1:0]   dec_pkt;

  fetch_pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl_i      (ctrl_i),
    .accept_i    (accept),
    .pc_o        (pc),
    .slot_mask_o (slot_mask),
    .fetch_en_o  (fetch_en)
  );

  inst_fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (ctrl_i.redirect),
    .fetch_en_i  (fetch_en),
    .pc_i        (pc),
    .slot_mask_i (slot_mask),
    .bus_req_o   (bus_req_o),
    .bus_resp_i  (bus_resp_i),
    .accept_o    (accept),
    .pkt_valid_o (pkt_valid),
    .pkt_o       (pkt),
    .pkt_ready_i (q_ready)
  );

  // an upper-word-only block moves into the first queue position
  assign wr_data[0].pc   = {pkt.pc[31:3], !pkt.slot_mask[0], 2'b00};
  assign wr_data[0].inst = pkt.slot_mask[0] ? pkt.inst[0] : pkt.inst[1];
  assign wr_data[1].pc   = {pkt.pc[31:3], 3'b100};
  assign wr_data[1].inst = pkt.inst[1];
  assign wr_num = (pkt_valid && !ctrl_i.redirect) ?
                  ({1'b0, pkt.slot_mask[0]} + {1'b0, pkt.slot_mask[1]}) : 2'd0;

  multi_port_fifo #(
    .entry_t (queue_entry_t),
    .DEPTH   (QUEUE_DEPTH)
  ) u_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (ctrl_i.redirect),
    .write_num_i   (wr_num),
    .write_data_i  (wr_data),
    .write_ready_o (q_ready),
    .read_valid_o  (rd_valid),
    .read_data_o   (rd_data),
    .read_num_i    (pop_num)
  );

  for (genvar p = 0; p < 2; p++) begin : g_dec
    inst_decoder u_dec (
      .inst_i (rd_data[p].inst),
      .info_o (dec_pkt[p].info),
      .regs_o (dec_pkt[p].regs)
    );
    assign dec_pkt[p].pc   = rd_data[p].pc;
    assign dec_pkt[p].inst = rd_data[p].inst;
    assign dec_pkt[p].imm  = rd_data[p].inst[25:0];
  end

  issue_buffer u_issue (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (ctrl_i.redirect),
    .entries_i       (dec_pkt),
    .entries_valid_i (rd_valid),
    .issue_i         (ctrl_i.issue),
    .pop_num_o       (pop_num),
    .inst_o          (inst_o),
    .inst_valid_o    (inst_valid_o)
  );

endmodule

/* logic/issue_buffer.sv */
module issue_buffer import frontend_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  issue_pkt_t [1:0] entries_i,
  input  logic [1:0]       entries_valid_i,
  input  logic [1:0]       issue_i,
  output logic [1:0]       pop_num_o,
  output issue_pkt_t [1:0] inst_o,
  output logic [1:0]       inst_valid_o
);

  issue_pkt_t [1:0] slot_q;
  issue_pkt_t [1:0] slot_d;
  logic [1:0]       valid_q;
  logic [1:0]       valid_d;
  logic [1:0]       issued;
  logic [1:0]       remain;
  logic [1:0]       avail;
  logic [1:0]       pop;

  always_comb begin
    // slot 0 goes first, a mask bit on an empty slot counts for nothing
    issued = 2'd0;
    if (valid_q[0] && issue_i[0]) begin
      issued = (valid_q[1] && issue_i[1]) ? 2'd2 : 2'd1;
    end
    // valid_q is always 00, 01 or 11
    remain = {1'b0, valid_q[0]} + {1'b0, valid_q[1]} - issued;
    avail  = {1'b0, entries_valid_i[0]} + {1'b0, entries_valid_i[1]};

    slot_d = slot_q;
    if (issued == 2'd1) begin
      slot_d[0] = slot_q[1];
    end

    pop = 2'd0;
    case (remain)
      2'd0: begin
        slot_d = entries_i;
        pop    = avail;
      end
      2'd1: begin
        slot_d[1] = entries_i[0];
        pop       = (avail != 2'd0) ? 2'd1 : 2'd0;
      end
      default: begin
      end
    endcase

    valid_d = (remain + pop == 2'd2) ? 2'b11 : ((remain + pop == 2'd1) ? 2'b01 : 2'b00);
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_d;
  end

  assign pop_num_o    = flush_i ? 2'd0 : pop;
  assign inst_o       = slot_q;
  assign inst_valid_o = valid_q;

endmodule

/* logic/inst_decoder.sv */
`include "frontend_defs.svh"

module inst_decoder import frontend_pkg::*; (
  input  logic [31:0]  inst_i,
  output decode_info_t info_o,
  output reg_info_t    regs_o
);

  inst_class_e cls;

  // opcode match, longest fields first
  always_comb begin
    if (inst_i[31:15] == `OPC_ADD_W_31_15) begin
      cls = CLS_ALU3R;
    end else if (inst_i[31:15] == `OPC_IDLE_31_15) begin
      cls = CLS_IDLE;
    end else if (inst_i[31:22] == `OPC_ADDI_W_31_22) begin
      cls = CLS_ALUI;
    end else if (inst_i[31:22] == `OPC_LD_W_31_22) begin
      cls = CLS_LOAD;
    end else if (inst_i[31:22] == `OPC_ST_W_31_22) begin
      cls = CLS_STORE;
    end else if (inst_i[31:26] == `OPC_BEQ_31_26) begin
      cls = CLS_BRANCH;
    end else if (inst_i[31:26] == `OPC_BL_31_26) begin
      cls = CLS_BL;
    end else if (inst_i[31:26] == `OPC_JIRL_31_26) begin
      cls = CLS_JIRL;
    end else begin
      cls = CLS_INVALID;
    end
  end

  always_comb begin
    info_o.cls    = cls;
    info_o.r0_sel = `REG_R0_NONE;
    info_o.r1_sel = `REG_R1_NONE;
    info_o.w_sel  = `REG_W_NONE;
    case (cls)
      CLS_ALU3R: begin
        info_o.r0_sel = `REG_R0_RK;
        info_o.r1_sel = `REG_R1_RJ;
        info_o.w_sel  = `REG_W_RD;
      end
      CLS_ALUI, CLS_LOAD, CLS_JIRL: begin
        info_o.r1_sel = `REG_R1_RJ;
        info_o.w_sel  = `REG_W_RD;
      end
      // store data and branch compare both come from rd
      CLS_STORE, CLS_BRANCH: begin
        info_o.r0_sel = `REG_R0_RD;
        info_o.r1_sel = `REG_R1_RJ;
      end
      CLS_BL: begin
        info_o.w_sel = `REG_W_R1;
      end
      default: begin
      end
    endcase
  end

  // unused selects read as register 0
  always_comb begin
    case (info_o.r0_sel)
      `REG_R0_RK: regs_o.r_reg[0] = inst_i[14:10];
      `REG_R0_RD: regs_o.r_reg[0] = inst_i[4:0];
      default:    regs_o.r_reg[0] = 5'd0;
    endcase
    regs_o.r_reg[1] = (info_o.r1_sel == `REG_R1_RJ) ? inst_i[9:5] : 5'd0;
    case (info_o.w_sel)
      `REG_W_RD: regs_o.w_reg = inst_i[4:0];
      `REG_W_R1: regs_o.w_reg = 5'd1;
      default:   regs_o.w_reg = 5'd0;
    endcase
  end

endmodule

/* logic/multi_port_fifo.sv */
module multi_port_fifo #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush_i,
  input  logic [1:0]      write_num_i,
  input  entry_t [1:0]    write_data_i,
  output logic            write_ready_o,
  output logic [1:0]      read_valid_o,
  output entry_t [1:0]    read_data_o,
  input  logic [1:0]      read_num_i
);

  localparam int PTR_W = $clog2(DEPTH);

  entry_t [DEPTH-1:0] mem_q;
  logic [PTR_W-1:0]   head_q;
  logic [PTR_W-1:0]   tail_q;
  logic [PTR_W:0]     count_q;
  logic [PTR_W:0]     wr_cnt;
  logic [PTR_W:0]     rd_cnt;
  logic [PTR_W-1:0]   tail_p1;
  logic [PTR_W-1:0]   head_p1;

  // room for a full two-entry write
  assign write_ready_o = (count_q <= (PTR_W + 1)'(DEPTH - 2));

  assign wr_cnt  = write_ready_o ? (PTR_W + 1)'(write_num_i) : '0;
  assign rd_cnt  = (PTR_W + 1)'(read_num_i);
  assign tail_p1 = tail_q + 1'b1;
  assign head_p1 = head_q + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + PTR_W'(rd_cnt);
      tail_q  <= tail_q + PTR_W'(wr_cnt);
      count_q <= count_q + wr_cnt - rd_cnt;
    end
  end

  // entries are written in order from the tail
  always_ff @(posedge clk) begin
    if (wr_cnt != '0) begin
      mem_q[tail_q] <= write_data_i[0];
    end
    if (wr_cnt == (PTR_W + 1)'(2)) begin
      mem_q[tail_p1] <= write_data_i[1];
    end
  end

  // two oldest entries, shown without a register
  assign read_data_o[0] = mem_q[head_q];
  assign read_data_o[1] = mem_q[head_p1];

  assign read_valid_o[0] = (count_q != '0);
  assign read_valid_o[1] = (count_q > (PTR_W + 1)'(1));

endmodule

/* logic/inst_fetch.sv */
module inst_fetch import frontend_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        fetch_en_i,
  input  logic [31:0] pc_i,
  input  logic [1:0]  slot_mask_i,
  output bus_req_t    bus_req_o,
  input  bus_resp_t   bus_resp_i,
  output logic        accept_o,
  output logic        pkt_valid_o,
  output fetch_pkt_t  pkt_o,
  input  logic        pkt_ready_i
);

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_WAIT = 2'd1,
    S_HOLD = 2'd2
  } state_e;

  state_e      state_q;
  logic        discard_q;
  logic [31:0] stale_addr_q;
  fetch_pkt_t  pkt_q;
  logic        drop;

  // a response is dropped if a flush came before or with it
  assign drop     = discard_q || flush_i;
  assign accept_o = (state_q == S_WAIT) && bus_resp_i.valid && !drop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (fetch_en_i) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (bus_resp_i.valid) begin
            discard_q <= 1'b0;
            if (!drop) begin
              state_q <= S_HOLD;
            end else if (!fetch_en_i) begin
              state_q <= S_IDLE;
            end
          end else if (flush_i) begin
            discard_q <= 1'b1;
          end
        end
        default: begin
          if (flush_i || pkt_ready_i) begin
            state_q <= fetch_en_i ? S_WAIT : S_IDLE;
          end
        end
      endcase
    end
  end

  // keep the outstanding address once the pc has moved to a redirect target
  always_ff @(posedge clk) begin
    if (state_q == S_WAIT && flush_i && !discard_q) begin
      stale_addr_q <= {pc_i[31:3], 3'b000};
    end
    if (accept_o) begin
      pkt_q.pc        <= {pc_i[31:3], 3'b000};
      pkt_q.slot_mask <= slot_mask_i;
      pkt_q.inst      <= bus_resp_i.data;
    end
  end

  assign bus_req_o.valid = (state_q == S_WAIT);
  assign bus_req_o.addr  = discard_q ? stale_addr_q : {pc_i[31:3], 3'b000};

  assign pkt_valid_o = (state_q == S_HOLD);
  assign pkt_o       = pkt_q;

endmodule

/* logic/fetch_pc_gen.sv */
module fetch_pc_gen import frontend_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  backend_ctrl_t ctrl_i,
  input  logic          accept_i,
  output logic [31:0]   pc_o,
  output logic [1:0]    slot_mask_o,
  output logic          fetch_en_o
);

  logic [31:0] pc_q;
  logic        idle_q;

  // redirect beats the sequential step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (ctrl_i.redirect) begin
      pc_q <= ctrl_i.target;
    end else if (accept_i) begin
      pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  // idle wait, interrupt wins when both arrive
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_q <= 1'b0;
    end else if (ctrl_i.irq) begin
      idle_q <= 1'b0;
    end else if (ctrl_i.wait_req) begin
      idle_q <= 1'b1;
    end
  end

  assign pc_o = pc_q;

  // upper word only when the pc points into the second half
  assign slot_mask_o = pc_q[2] ? 2'b10 : 2'b11;

  assign fetch_en_o = !idle_q;

endmodule

/* logic/frontend_pkg.sv */
package frontend_pkg;

  // opcode class from the decoder
  typedef enum logic [3:0] {
    CLS_ALU3R   = 4'd0,
    CLS_ALUI    = 4'd1,
    CLS_LOAD    = 4'd2,
    CLS_STORE   = 4'd3,
    CLS_BRANCH  = 4'd4,
    CLS_BL      = 4'd5,
    CLS_JIRL    = 4'd6,
    CLS_IDLE    = 4'd7,
    CLS_INVALID = 4'd8
  } inst_class_e;

  // r_reg[0] follows r0_sel, r_reg[1] follows r1_sel
  typedef struct packed {
    logic [1:0][4:0] r_reg;
    logic [4:0]      w_reg;
  } reg_info_t;

  // select values are the REG_* macros of frontend_defs.svh
  typedef struct packed {
    inst_class_e cls;
    logic [1:0]  r0_sel;
    logic        r1_sel;
    logic [1:0]  w_sel;
  } decode_info_t;

  // one aligned fetch block, slot 0 is the lower word
  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0]       slot_mask;
    logic [1:0][31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } queue_entry_t;

  typedef struct packed {
    logic [31:0]  pc;
    logic [31:0]  inst;
    decode_info_t info;
    reg_info_t    regs;
    logic [25:0]  imm;
  } issue_pkt_t;

  // address is always 8-byte aligned
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } bus_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } bus_resp_t;

  typedef struct packed {
    logic        redirect;
    logic [31:0] target;
    logic        wait_req;
    logic        irq;
    logic [1:0]  issue;
  } backend_ctrl_t;

endpackage

/* include/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH
// opcode match values, compared against the field named in the suffix
`define OPC_ADD_W_31_15  17'h00020
`define OPC_ADDI_W_31_22 10'h00a
`define OPC_LD_W_31_22   10'h0a2
`define OPC_ST_W_31_22   10'h0a6
`define OPC_BEQ_31_26    6'h16
`define OPC_BL_31_26     6'h15
`define OPC_JIRL_31_26   6'h13
`define OPC_IDLE_31_15   17'h00c91
// register select codes
`define REG_R0_NONE 2'd0
`define REG_R0_RK   2'd1
`define REG_R0_RD   2'd2
`define REG_R1_NONE 1'b0
`define REG_R1_RJ   1'b1
`define REG_W_NONE  2'd0
`define REG_W_RD    2'd1
`define REG_W_R1    2'd2
`endif
